// File: rtl/edp_defines.svh
`ifndef EDP_DEFINES_SVH
`define EDP_DEFINES_SVH

// Machine word, bit 0 is the sign
`define EDP_WORD_W 36

// Left half is bits 0..17, right half 18..35
`define EDP_HALF_W 18

// Fast memory geometry
// One block per AC set, selected by the APR
`define EDP_FM_BLOCKS 8

// Sixteen ACs in each block
`define EDP_FM_WORDS 16

`endif

// File: rtl/cramPkg.sv
package cramPkg;

  // AD function unit operations
  typedef enum logic [2:0] {
    adAdd, adSub, adAnd, adOr, adXor, adPassA, adPassB, adOnes
  } tAdFunc;

  // ADA source
  typedef enum logic [1:0] {adaAr, adaArx, adaMq, adaZero} tAdaSel;

  // ADB source, shifted forms borrow low bits from BRX or ARX
  typedef enum logic [1:0] {adbFm, adbBrX2, adbBr, adbArX4} tAdbSel;

  // AR half and ARX word sources
  typedef enum logic [2:0] {
    arSelZero, arSelCache, arSelAd, arSelEbus,
    arSelAdx, arSelMq, arSelAdShl, arSelAdxShl
  } tArSel;

  // MQ universal shift register function
  typedef enum logic [1:0] {mqLoad, mqShl, mqShr, mqHold} tMqSel;

  // Data path fields of the microword
  typedef struct packed {
    tAdFunc adFunc;
    tAdaSel ada;
    tAdbSel adb;
    logic   adLong;
    logic   adCarryIn;
    tArSel  arlSel;
    tArSel  arrSel;
    logic   arlLoad;
    logic   arrLoad;
    logic   arlClr;
    logic   arrClr;
    tArSel  arxSel;
    logic   arxLoad;
    tMqSel  mqSel;
    logic   brLoad;
    logic   brxLoad;
  } tCramEdp;

endpackage

// File: rtl/ebusPkg.sv
`include "edp_defines.svh"

package ebusPkg;

  // Full machine word and one half of it
  typedef logic [0:`EDP_WORD_W-1] tWord;
  typedef logic [0:`EDP_HALF_W-1] tHalf;

  // Register named by a diagnostic read
  // 0 AR, 1 BR, 2 MQ, 3 FM, 4 BRX, 5 ARX, 6 ADX, 7 AD
  typedef logic [0:2] tDiagFunc;

  // What this board puts on the EBUS
  typedef struct packed {
    logic driving;
    tWord data;
  } tEbusDriver;

endpackage

// File: rtl/adAlu.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module adAlu (
  input  cramPkg::tCramEdp cram,
  input  ebusPkg::tWord    ar,
  input  ebusPkg::tWord    arx,
  input  ebusPkg::tWord    br,
  input  ebusPkg::tWord    brx,
  input  ebusPkg::tWord    mq,
  input  ebusPkg::tWord    fm,
  output ebusPkg::tWord    ad,
  output ebusPkg::tWord    adx,
  output logic             adCarry0,
  output logic             adOverflow
);
  import cramPkg::*;
  import ebusPkg::*;

  tWord ada;
  tWord adb;
  tWord adxb;
  tWord adbOp;
  tWord adxbOp;
  tWord adSum;
  logic isArith;
  logic lowCarry;
  logic adCarry35;
  logic carry1;
  logic carry0;
  logic [`EDP_WORD_W:0]   adxSum;
  logic [`EDP_WORD_W-1:0] adLow;

  // ADA mux
  always_comb begin
    case (cram.ada)
      adaAr:   ada = ar;
      adaArx:  ada = arx;
      adaMq:   ada = mq;
      default: ada = '0;
    endcase
  end

  // ADB mux, with ADXB shifted so the pair acts as one 72-bit operand
  always_comb begin
    case (cram.adb)
      adbFm: begin
        adb  = fm;
        adxb = brx;
      end
      adbBrX2: begin
        adb  = {br[1:`EDP_WORD_W-1], brx[0]};
        adxb = {brx[1:`EDP_WORD_W-1], 1'b0};
      end
      adbBr: begin
        adb  = br;
        adxb = brx;
      end
      default: begin
        adb  = {ar[2:`EDP_WORD_W-1], arx[0:1]};
        adxb = {arx[2:`EDP_WORD_W-1], 2'b00};
      end
    endcase
  end

  // Adder, ADX first since its carry out may feed AD
  always_comb begin
    isArith   = (cram.adFunc == adAdd) || (cram.adFunc == adSub);
    lowCarry  = (cram.adFunc == adSub) ? 1'b1 : cram.adCarryIn;
    adbOp     = (cram.adFunc == adSub) ? ~adb : adb;
    adxbOp    = (cram.adFunc == adSub) ? ~adxb : adxb;
    adxSum    = {1'b0, arx} + {1'b0, adxbOp} + lowCarry;
    adCarry35 = cram.adLong ? adxSum[`EDP_WORD_W] : lowCarry;
    // Bit 0 done separately to expose the carry into it
    adLow     = {1'b0, ada[1:`EDP_WORD_W-1]} + {1'b0, adbOp[1:`EDP_WORD_W-1]} + adCarry35;
    carry1    = adLow[`EDP_WORD_W-1];
    carry0    = (ada[0] & adbOp[0]) | ((ada[0] ^ adbOp[0]) & carry1);
    adSum     = {ada[0] ^ adbOp[0] ^ carry1, adLow[`EDP_WORD_W-2:0]};
  end

  // Function select, flags only mean something for add and subtract
  always_comb begin
    adCarry0   = isArith & carry0;
    adOverflow = isArith & (carry0 ^ carry1);
    case (cram.adFunc)
      adAnd: begin
        ad  = ada & adb;
        adx = arx & adxb;
      end
      adOr: begin
        ad  = ada | adb;
        adx = arx | adxb;
      end
      adXor: begin
        ad  = ada ^ adb;
        adx = arx ^ adxb;
      end
      adPassA: begin
        ad  = ada;
        adx = arx;
      end
      adPassB: begin
        ad  = adb;
        adx = adxb;
      end
      adOnes: begin
        ad  = '1;
        adx = '1;
      end
      default: begin
        ad  = adSum;
        adx = adxSum[`EDP_WORD_W-1:0];
      end
    endcase
  end

endmodule

// File: rtl/edpRegs.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module edpRegs (
  input  logic             eboxClk,
  input  logic             rst,
  input  cramPkg::tCramEdp cram,
  input  ebusPkg::tWord    cacheData,
  input  ebusPkg::tWord    ebusIn,
  input  ebusPkg::tWord    ad,
  input  ebusPkg::tWord    adx,
  input  logic             adCarry0,
  output ebusPkg::tWord    ar,
  output ebusPkg::tWord    arx,
  output ebusPkg::tWord    br,
  output ebusPkg::tWord    brx,
  output ebusPkg::tWord    mq
);
  import cramPkg::*;
  import ebusPkg::*;

  tWord arlWord;
  tWord arrWord;
  tWord arxNext;
  tHalf arlNext;
  tHalf arrNext;

  // Shared source mux for AR halves and ARX
  function automatic tWord arSource(input tArSel sel);
    case (sel)
      arSelZero:   arSource = '0;
      arSelCache:  arSource = cacheData;
      arSelAd:     arSource = ad;
      arSelEbus:   arSource = ebusIn;
      arSelAdx:    arSource = adx;
      arSelMq:     arSource = mq;
      // One place left, next word supplies the low bit
      arSelAdShl:  arSource = {ad[1:`EDP_WORD_W-1], adx[0]};
      default:     arSource = {adx[1:`EDP_WORD_W-1], mq[0]};
    endcase
  endfunction

  always_comb begin
    arlWord = arSource(cram.arlSel);
    arrWord = arSource(cram.arrSel);
    arxNext = arSource(cram.arxSel);
    arlNext = arlWord[0:`EDP_HALF_W-1];
    arrNext = arrWord[`EDP_HALF_W:`EDP_WORD_W-1];
  end

  // AR halves load and clear on their own
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      ar <= '0;
    end else begin
      if (cram.arlClr) begin
        ar[0:`EDP_HALF_W-1] <= '0;
      end else if (cram.arlLoad) begin
        ar[0:`EDP_HALF_W-1] <= arlNext;
      end
      if (cram.arrClr) begin
        ar[`EDP_HALF_W:`EDP_WORD_W-1] <= '0;
      end else if (cram.arrLoad) begin
        ar[`EDP_HALF_W:`EDP_WORD_W-1] <= arrNext;
      end
    end
  end

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      arx <= '0;
    end else if (cram.arxLoad) begin
      arx <= arxNext;
    end
  end

  // BR and BRX only ever copy AR and ARX
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      br  <= '0;
      brx <= '0;
    end else begin
      if (cram.brLoad) begin
        br <= ar;
      end
      if (cram.brxLoad) begin
        brx <= arx;
      end
    end
  end

  // MQ as a universal shift register
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      mq <= '0;
    end else begin
      case (cram.mqSel)
        mqLoad:  mq <= ad;
        // Multiply step, AD moves up with its carry out behind it
        mqShl:   mq <= {ad[1:`EDP_WORD_W-1], adCarry0};
        // Sign fills from the left
        mqShr:   mq <= {mq[0], mq[0:`EDP_WORD_W-2]};
        default: mq <= mq;
      endcase
    end
  end

endmodule

// File: rtl/fastMem.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module fastMem (
  input  logic          eboxClk,
  input  logic [0:$clog2(`EDP_FM_BLOCKS * `EDP_FM_WORDS)-1] address,
  input  logic          writeL,
  input  logic          writeR,
  input  ebusPkg::tWord writeData,
  output ebusPkg::tWord readData,
  output logic          parity
);
  import ebusPkg::*;

  tWord mem [0:`EDP_FM_BLOCKS * `EDP_FM_WORDS - 1];

  // ACs start out cleared
  initial begin
    for (int i = 0; i < `EDP_FM_BLOCKS * `EDP_FM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Halfword write enables
  always_ff @(posedge eboxClk) begin
    if (writeL) begin
      mem[address][0:`EDP_HALF_W-1] <= writeData[0:`EDP_HALF_W-1];
    end
    if (writeR) begin
      mem[address][`EDP_HALF_W:`EDP_WORD_W-1] <= writeData[`EDP_HALF_W:`EDP_WORD_W-1];
    end
  end

  assign readData = mem[address];
  assign parity   = ^readData;

endmodule

// File: rtl/ebusDriver.sv
`timescale 1ns/100ps

module ebusDriver (
  input  logic               eboxClk,
  input  logic               rst,
  input  logic               adToEbus,
  input  logic               diagRead,
  input  ebusPkg::tDiagFunc  diagFunc,
  input  ebusPkg::tWord      ar,
  input  ebusPkg::tWord      br,
  input  ebusPkg::tWord      mq,
  input  ebusPkg::tWord      fm,
  input  ebusPkg::tWord      brx,
  input  ebusPkg::tWord      arx,
  input  ebusPkg::tWord      adx,
  input  ebusPkg::tWord      ad,
  output ebusPkg::tEbusDriver ebusOut
);
  import ebusPkg::*;

  tWord src;

  // AD request beats whatever the diag function names
  always_comb begin
    if (adToEbus) begin
      src = ad;
    end else begin
      case (diagFunc)
        3'd0:    src = ar;
        3'd1:    src = br;
        3'd2:    src = mq;
        3'd3:    src = fm;
        3'd4:    src = brx;
        3'd5:    src = arx;
        3'd6:    src = adx;
        default: src = ad;
      endcase
    end
  end

  // Bus is quiet and zero unless asked for last cycle
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      ebusOut <= '0;
    end else if (adToEbus || diagRead) begin
      ebusOut.driving <= 1'b1;
      ebusOut.data    <= src;
    end else begin
      ebusOut <= '0;
    end
  end

endmodule

// File: rtl/edp.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module edp (
  input  logic                             eboxClk,
  input  logic                             rst,
  input  cramPkg::tCramEdp                 cram,
  input  ebusPkg::tWord                    cacheData,
  input  ebusPkg::tWord                    ebusIn,
  input  logic [0:$clog2(`EDP_FM_BLOCKS)-1] fmBlock,
  input  logic [0:$clog2(`EDP_FM_WORDS)-1]  fmAdr,
  input  logic                             fmWriteL,
  input  logic                             fmWriteR,
  input  logic                             adToEbus,
  input  logic                             diagRead,
  input  ebusPkg::tDiagFunc                diagFunc,
  output ebusPkg::tWord                    ar,
  output ebusPkg::tWord                    arx,
  output ebusPkg::tWord                    br,
  output ebusPkg::tWord                    brx,
  output ebusPkg::tWord                    mq,
  output ebusPkg::tWord                    ad,
  output ebusPkg::tWord                    adx,
  output logic                             adCarry0,
  output logic                             adOverflow,
  output ebusPkg::tWord                    fm,
  output logic                             fmParity,
  output ebusPkg::tEbusDriver              ebusOut
);

  // Word registers around the adder
  edpRegs regs_i (
    .eboxClk(eboxClk), .rst(rst), .cram(cram),
    .cacheData(cacheData), .ebusIn(ebusIn),
    .ad(ad), .adx(adx), .adCarry0(adCarry0),
    .ar(ar), .arx(arx), .br(br), .brx(brx), .mq(mq)
  );

  adAlu alu_i (
    .cram(cram),
    .ar(ar), .arx(arx), .br(br), .brx(brx), .mq(mq), .fm(fm),
    .ad(ad), .adx(adx), .adCarry0(adCarry0), .adOverflow(adOverflow)
  );

  // AC block and AC number form the fast memory address
  fastMem fm_i (
    .eboxClk(eboxClk), .address({fmBlock, fmAdr}),
    .writeL(fmWriteL), .writeR(fmWriteR), .writeData(ar),
    .readData(fm), .parity(fmParity)
  );

  ebusDriver ebus_i (
    .eboxClk(eboxClk), .rst(rst),
    .adToEbus(adToEbus), .diagRead(diagRead), .diagFunc(diagFunc),
    .ar(ar), .br(br), .mq(mq), .fm(fm),
    .brx(brx), .arx(arx), .adx(adx), .ad(ad),
    .ebusOut(ebusOut)
  );

endmodule

// File: dv/edp_props.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module edpProps (
  input logic                  eboxClk,
  input logic                  rst,
  input cramPkg::tCramEdp      cram,
  input ebusPkg::tWord         cacheData,
  input logic [0:$clog2(`EDP_FM_BLOCKS * `EDP_FM_WORDS)-1] fmAddress,
  input logic                  fmWriteL, fmWriteR, adToEbus, diagRead,
  input ebusPkg::tDiagFunc     diagFunc,
  input ebusPkg::tWord         ar, arx, br, brx, mq, ad, adx, fm,
  input logic                  adCarry0, adOverflow, fmParity,
  input ebusPkg::tEbusDriver   ebusOut
);
  import cramPkg::*;
  import ebusPkg::*;

  int failCount = 0;
  tWord namedReg;
  logic arBrSel;
  logic carryInto0;
  logic [`EDP_WORD_W:0] shortSum;
  logic [2*`EDP_WORD_W-1:0] longSum;
  tHalf arlExp;
  tHalf arrExp;
  tWord mqExp;
  tWord fmExp;
  logic [0:$clog2(`EDP_FM_BLOCKS * `EDP_FM_WORDS)-1] prevAddress;
  tEbusDriver busExp;

  // Reference result of one short AD operation
  function automatic tWord expectAd(input tAdFunc func, input tWord a, input tWord b,
                                    input logic cin);
    case (func)
      adAdd:   return a + b + tWord'(cin);
      adSub:   return a + ~b + tWord'(1);
      adAnd:   return a & b;
      adOr:    return a | b;
      adXor:   return a ^ b;
      adPassA: return a;
      adPassB: return b;
      default: return '1;
    endcase
  endfunction

  // Diag code order, 0 AR up to 7 AD
  always_comb begin
    case (diagFunc)
      3'd0:    namedReg = ar;
      3'd1:    namedReg = br;
      3'd2:    namedReg = mq;
      3'd3:    namedReg = fm;
      3'd4:    namedReg = brx;
      3'd5:    namedReg = arx;
      3'd6:    namedReg = adx;
      default: namedReg = ad;
    endcase
  end

  always_comb begin
    arBrSel    = (cram.ada == adaAr) && (cram.adb == adbBr);
    shortSum   = {1'b0, ar} + {1'b0, br} + 37'(cram.adCarryIn);
    longSum    = {ar, arx} + {br, brx} + 72'(cram.adCarryIn);
    // Sign bit sum tells us what carried into bit 0
    carryInto0 = shortSum[`EDP_WORD_W-1] ^ ar[0] ^ br[0];
  end

  // What each register should hold one edge later
  always_ff @(posedge eboxClk) begin
    if (cram.arlClr) begin
      arlExp <= '0;
    end else begin
      arlExp <= cram.arlLoad ? cacheData[0:`EDP_HALF_W-1] : ar[0:`EDP_HALF_W-1];
    end
    if (cram.arrClr) begin
      arrExp <= '0;
    end else begin
      arrExp <= cram.arrLoad ? cacheData[`EDP_HALF_W:`EDP_WORD_W-1]
                             : ar[`EDP_HALF_W:`EDP_WORD_W-1];
    end
    mqExp       <= {ad[1:`EDP_WORD_W-1], adCarry0};
    fmExp       <= {ar[0:`EDP_HALF_W-1], fm[`EDP_HALF_W:`EDP_WORD_W-1]};
    prevAddress <= fmAddress;
    busExp      <= (adToEbus || diagRead) ? {1'b1, (adToEbus ? ad : namedReg)} : '0;
  end

  assert property (@(posedge eboxClk)
    rst |=> {ar, arx, br, brx, mq, ebusOut.driving} == '0)
    else begin
      failCount++;
      $error("ERR %0t ar,arx,br,brx,mq,driving got %h expected 0", $time,
             {ar, arx, br, brx, mq, ebusOut.driving});
    end

  assert property (@(posedge eboxClk) disable iff (rst)
    !cram.adLong && arBrSel |-> ad == expectAd(cram.adFunc, ar, br, cram.adCarryIn))
    else begin
      failCount++;
      $error("ERR %0t ad got %h expected %h", $time, ad,
             expectAd(cram.adFunc, ar, br, cram.adCarryIn));
    end

  assert property (@(posedge eboxClk) disable iff (rst)
    !cram.adLong && arBrSel && cram.adFunc == adAdd |->
      {adCarry0, adOverflow} == {shortSum[`EDP_WORD_W], carryInto0 ^ shortSum[`EDP_WORD_W]})
    else begin
      failCount++;
      $error("ERR %0t adCarry0,adOverflow got %b expected %b", $time, {adCarry0, adOverflow},
             {shortSum[`EDP_WORD_W], carryInto0 ^ shortSum[`EDP_WORD_W]});
    end

  assert property (@(posedge eboxClk) disable iff (rst)
    cram.adLong && arBrSel && cram.adFunc == adAdd |-> {ad, adx} == longSum)
    else begin
      failCount++;
      $error("ERR %0t ad,adx got %h expected %h", $time, {ad, adx}, longSum);
    end

  // Half loads are only modelled for the cache source
  assert property (@(posedge eboxClk) disable iff (rst)
    (cram.arlClr || !cram.arlLoad || cram.arlSel == arSelCache) &&
    (cram.arrClr || !cram.arrLoad || cram.arrSel == arSelCache) |=> ar == {arlExp, arrExp})
    else begin
      failCount++;
      $error("ERR %0t ar got %h expected %h", $time, ar, {arlExp, arrExp});
    end

  assert property (@(posedge eboxClk) disable iff (rst)
    cram.mqSel == mqShl |=> mq == mqExp)
    else begin
      failCount++;
      $error("ERR %0t mq got %h expected %h", $time, mq, mqExp);
    end

  assert property (@(posedge eboxClk) disable iff (rst)
    fmWriteL && !fmWriteR |=> (fmAddress != prevAddress) || (fm == fmExp))
    else begin
      failCount++;
      $error("ERR %0t fm got %h expected %h", $time, fm, fmExp);
    end

  assert property (@(posedge eboxClk) fmParity == ^fm)
    else begin
      failCount++;
      $error("ERR %0t fmParity got %b expected %b", $time, fmParity, ^fm);
    end

  assert property (@(posedge eboxClk) disable iff (rst)
    1'b1 |=> ebusOut == busExp)
    else begin
      failCount++;
      $error("ERR %0t ebusOut got %h expected %h", $time, ebusOut, busExp);
    end

endmodule

bind edp edpProps props_i (
  .eboxClk(eboxClk), .rst(rst), .cram(cram), .cacheData(cacheData),
  .fmAddress({fmBlock, fmAdr}), .fmWriteL(fmWriteL), .fmWriteR(fmWriteR),
  .adToEbus(adToEbus), .diagRead(diagRead), .diagFunc(diagFunc),
  .ar(ar), .arx(arx), .br(br), .brx(brx), .mq(mq),
  .ad(ad), .adx(adx), .fm(fm),
  .adCarry0(adCarry0), .adOverflow(adOverflow), .fmParity(fmParity),
  .ebusOut(ebusOut)
);

// File: dv/edpTb.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module edpTb;
  import cramPkg::*;
  import ebusPkg::*;

  localparam int ResetCycles = 8;
  localparam int NumOps = 200;
  // Two operand loads, eight functions, one long add, four half cycles
  localparam int OpCycles = 15;
  // Idle cycles at the end so the last checks complete
  localparam int DrainCycles = 2;
  localparam int TimeoutCycles = ResetCycles + NumOps * OpCycles + DrainCycles + 50;

  logic eboxClk;
  logic rst;
  tCramEdp cram;
  tWord cacheData;
  tWord ebusIn;
  logic [0:$clog2(`EDP_FM_BLOCKS)-1] fmBlock;
  logic [0:$clog2(`EDP_FM_WORDS)-1] fmAdr;
  logic fmWriteL;
  logic fmWriteR;
  logic adToEbus;
  logic diagRead;
  tDiagFunc diagFunc;
  tWord ar;
  tWord arx;
  tWord br;
  tWord brx;
  tWord mq;
  tWord ad;
  tWord adx;
  logic adCarry0;
  logic adOverflow;
  tWord fm;
  logic fmParity;
  tEbusDriver ebusOut;

  integer seed = 32'h6fc2022f;
  int timeoutCount = 0;

  edp dut_i (.*);

  initial begin
    eboxClk = 1'b0;
  end

  always #5 eboxClk = ~eboxClk;

  task automatic nextCycle();
    @(posedge eboxClk);
    #1;
  endtask

  function automatic tWord randomWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[3:0], lo};
  endfunction

  // Short add of AR and BR with every load off
  task automatic idleControls();
    cram = '0;
    cram.adb = adbBr;
    cram.mqSel = mqHold;
    fmWriteL = 1'b0;
    fmWriteR = 1'b0;
    adToEbus = 1'b0;
    diagRead = 1'b0;
  endtask

  // AR from the cache word, ARX from the EBUS
  task automatic loadOperands(input tWord a, input tWord x, input logic copyDown);
    idleControls();
    cram.arlSel = arSelCache;
    cram.arrSel = arSelCache;
    cram.arlLoad = 1'b1;
    cram.arrLoad = 1'b1;
    cram.arxSel = arSelEbus;
    cram.arxLoad = 1'b1;
    cram.brLoad = copyDown;
    cram.brxLoad = copyDown;
    cacheData = a;
    ebusIn = x;
    nextCycle();
  endtask

  task automatic runFunctions();
    logic [31:0] r;
    int f;
    for (f = 0; f < 8; f++) begin
      r = $random(seed);
      idleControls();
      cram.adFunc = tAdFunc'(f);
      cram.adCarryIn = r[0];
      cram.mqSel = mqShl;
      diagRead = r[1];
      adToEbus = r[2] & r[3];
      diagFunc = r[6:4];
      fmWriteL = r[7];
      fmWriteR = r[8] & r[9];
      nextCycle();
    end
    // One 72-bit add over AR,ARX and BR,BRX
    idleControls();
    cram.adLong = 1'b1;
    cram.adCarryIn = r[10];
    nextCycle();
  endtask

  task automatic halfCycles();
    idleControls();
    cram.arlSel = arSelCache;
    cram.arrSel = arSelCache;
    cram.arlLoad = 1'b1;
    cacheData = randomWord();
    nextCycle();
    cram.arlLoad = 1'b0;
    cram.arrLoad = 1'b1;
    cacheData = randomWord();
    nextCycle();
    // Clear together with load
    cram.arlClr = 1'b1;
    cram.arlLoad = 1'b1;
    cram.arrLoad = 1'b0;
    cacheData = randomWord();
    nextCycle();
    cram.arlClr = 1'b0;
    cram.arlLoad = 1'b0;
    cram.arrClr = 1'b1;
    cram.arrLoad = 1'b1;
    nextCycle();
  endtask

  task automatic finishRun();
    int failures;
    failures = dut_i.props_i.failCount + timeoutCount;
    $display("Assertion failures: %0d, timeouts: %0d", dut_i.props_i.failCount,
             timeoutCount);
    if (failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    logic [31:0] r;
    int op;
    rst = 1'b1;
    cacheData = '0;
    ebusIn = '0;
    fmBlock = '0;
    fmAdr = '0;
    diagFunc = '0;
    idleControls();
    repeat (ResetCycles) nextCycle();
    rst = 1'b0;
    for (op = 0; op < NumOps; op++) begin
      r = $random(seed);
      fmBlock = r[2:0];
      fmAdr = r[6:3];
      loadOperands(randomWord(), randomWord(), 1'b0);
      // BR and BRX take the first pair while the second loads
      loadOperands(randomWord(), randomWord(), 1'b1);
      runFunctions();
      halfCycles();
    end
    idleControls();
    repeat (DrainCycles) nextCycle();
    finishRun();
  end

  initial begin
    int cycleCount;
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge eboxClk);
      cycleCount++;
    end
    timeoutCount = 1;
    $display("Timeout: stimulus did not finish within %0d cycles", TimeoutCycles);
    finishRun();
  end

endmodule

// File: sim.f
+incdir+rtl
rtl/cramPkg.sv
rtl/ebusPkg.sv
rtl/adAlu.sv
rtl/edpRegs.sv
rtl/fastMem.sv
rtl/ebusDriver.sv
rtl/edp.sv
dv/edp_props.sv
dv/edpTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= edpTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100000
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
